// ==== design/rv32i_types.sv ====
package rv32i_types;

typedef logic [31:0] rv32i_word;
typedef logic [4:0]  rv32i_reg;

typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_csr   = 7'b1110011
} rv32i_opcode;

// add, sll, xor, srl, or and and sit on their funct3 codes
typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
} alu_ops;

typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
} branch_funct3_t;

typedef enum logic [2:0] {
    add  = 3'b000,
    sll  = 3'b001,
    slt  = 3'b010,
    sltu = 3'b011,
    axor = 3'b100,
    sr   = 3'b101,
    aor  = 3'b110,
    aand = 3'b111
} arith_funct3_t;

typedef enum logic {rs1_out, pc_out} alumux1_sel_t;
typedef enum logic [2:0] {i_imm, u_imm, b_imm, s_imm, rs2_out} alumux2_sel_t;
typedef enum logic {cmp_rs2_out, cmp_i_imm} cmpmux_sel_t;
typedef enum logic [1:0] {rf_alu_out, rf_br_en, rf_u_imm} regfilemux_sel_t;

typedef struct packed {
    rv32i_opcode     opcode;
    alu_ops          aluop;
    branch_funct3_t  cmpop;
    rv32i_reg        rd;
    logic            load_regfile;
    regfilemux_sel_t regfilemux_sel;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
} rv32i_control_word;

endpackage : rv32i_types

// ==== design/id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if;
    import rv32i_types::*;

    logic              valid;
    rv32i_control_word ctrl;
    rv32i_word         pc;
    rv32i_word         rs1_data;
    rv32i_word         rs2_data;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;

    modport decode (
        output valid, ctrl, pc, rs1_data, rs2_data, i_imm, s_imm, b_imm, u_imm
    );

    modport execute (
        input valid, ctrl, pc, rs1_data, rs2_data, i_imm, s_imm, b_imm, u_imm
    );
endinterface : id_ex_if

// ==== design/control_rom.sv ====
`timescale 1ns/1ps

module control_rom
(
    input  rv32i_types::rv32i_word         data,
    input  rv32i_types::rv32i_word         u_imm,
    output rv32i_types::rv32i_control_word ctrl
);
    import rv32i_types::*;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        alt_op;

    assign opcode = rv32i_opcode'(data[6:0]);
    assign funct3 = data[14:12];
    assign alt_op = u_imm[30]; // funct7 bit 5 lives in the upper immediate bits too

    function automatic void set_defaults();
        ctrl.opcode         = opcode;
        ctrl.aluop          = alu_add;
        ctrl.cmpop          = branch_funct3_t'(funct3);
        ctrl.rd             = data[11:7];
        ctrl.load_regfile   = 1'b0;
        ctrl.regfilemux_sel = rf_alu_out;
        ctrl.alumux1_sel    = rs1_out;
        ctrl.alumux2_sel    = i_imm;
        ctrl.cmpmux_sel     = cmp_rs2_out;
    endfunction

    function automatic void write_reg(regfilemux_sel_t sel);
        ctrl.load_regfile   = 1'b1;
        ctrl.regfilemux_sel = sel;
    endfunction

    function automatic void set_alu(alumux1_sel_t sel1, alumux2_sel_t sel2, alu_ops op);
        ctrl.alumux1_sel = sel1;
        ctrl.alumux2_sel = sel2;
        ctrl.aluop       = op;
    endfunction

    function automatic void set_cmp(cmpmux_sel_t sel, branch_funct3_t op);
        ctrl.cmpmux_sel = sel;
        ctrl.cmpop      = op;
    endfunction

    // OP-IMM and OP share everything but the second operand and the sub variant
    function automatic void decode_arith(alumux2_sel_t sel2, cmpmux_sel_t csel, logic reg_op);
        unique case (arith_funct3_t'(funct3))
            slt:
            begin
                write_reg(rf_br_en);
                set_cmp(csel, blt);
            end
            sltu:
            begin
                write_reg(rf_br_en);
                set_cmp(csel, bltu);
            end
            sr:
            begin
                write_reg(rf_alu_out);
                if (alt_op)
                    set_alu(rs1_out, sel2, alu_sra);
                else
                    set_alu(rs1_out, sel2, alu_srl);
            end
            add:
            begin
                write_reg(rf_alu_out);
                if (reg_op && alt_op)
                    set_alu(rs1_out, sel2, alu_sub);
                else
                    set_alu(rs1_out, sel2, alu_add);
            end
            default:
            begin
                write_reg(rf_alu_out);
                set_alu(rs1_out, sel2, alu_ops'(funct3));
            end
        endcase
    endfunction

    always_comb
    begin
        set_defaults();
        case (opcode)
            op_lui:
                write_reg(rf_u_imm);
            op_auipc:
            begin
                write_reg(rf_alu_out);
                set_alu(pc_out, rv32i_types::u_imm, alu_add); // port shadows the select name
            end
            op_br:
            begin
                set_alu(pc_out, b_imm, alu_add);
                set_cmp(cmp_rs2_out, branch_funct3_t'(funct3));
            end
            op_imm:
                decode_arith(i_imm, cmp_i_imm, 1'b0);
            op_reg:
                decode_arith(rs2_out, cmp_rs2_out, 1'b1);
            default:
                ctrl = '0; // loads, stores, jumps and system do nothing in this slice
        endcase
    end
endmodule : control_rom

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  rv32i_types::rv32i_reg  rd,
    input  rv32i_types::rv32i_word wdata,
    input  rv32i_types::rv32i_reg  rs1,
    input  rv32i_types::rv32i_reg  rs2,
    output rv32i_types::rv32i_word rs1_data,
    output rv32i_types::rv32i_word rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [1:31]; // x0 has no storage and always reads zero

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
        begin
            regs[rd] <= wdata;
        end
    end

    function automatic rv32i_word read_port(rv32i_reg idx);
        if (idx == '0)
            return '0;
        else if (we && idx == rd)
            return wdata; // same-cycle write is forwarded to the reader
        else
            return regs[idx];
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end
endmodule : regfile

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  rv32i_types::rv32i_word instr,
    input  rv32i_types::rv32i_word pc,
    input  logic                   wb_we,
    input  rv32i_types::rv32i_reg  wb_rd,
    input  rv32i_types::rv32i_word wb_data,
    id_ex_if.decode                out
);
    import rv32i_types::*;

    rv32i_reg          rs1;
    rv32i_reg          rs2;
    rv32i_word         rs1_data;
    rv32i_word         rs2_data;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;
    rv32i_control_word ctrl;

    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};

    control_rom rom0 (.data(instr), .u_imm(u_imm), .ctrl(ctrl));

    regfile rf0 (
        .clk(clk), .rst(rst), .we(wb_we), .rd(wb_rd), .wdata(wb_data),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
            out.valid <= 1'b0;
        else
            out.valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        out.ctrl     <= ctrl;
        out.pc       <= pc;
        out.rs1_data <= rs1_data;
        out.rs2_data <= rs2_data;
        out.i_imm    <= i_imm;
        out.s_imm    <= s_imm;
        out.b_imm    <= b_imm;
        out.u_imm    <= u_imm;
    end
endmodule : decode_stage

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
(
    id_ex_if.execute               in,
    output logic                   wb_we,
    output rv32i_types::rv32i_reg  wb_rd,
    output rv32i_types::rv32i_word wb_data,
    output logic                   br_valid,
    output logic                   br_taken,
    output rv32i_types::rv32i_word br_target
);
    import rv32i_types::*;

    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_result;
    rv32i_word cmp_b;
    logic      br_en;

    always_comb
    begin
        unique case (in.ctrl.alumux1_sel)
            pc_out:  alu_a = in.pc;
            default: alu_a = in.rs1_data;
        endcase

        unique case (in.ctrl.alumux2_sel)
            u_imm:   alu_b = in.u_imm;
            b_imm:   alu_b = in.b_imm;
            s_imm:   alu_b = in.s_imm;
            rs2_out: alu_b = in.rs2_data;
            default: alu_b = in.i_imm;
        endcase

        cmp_b = (in.ctrl.cmpmux_sel == cmp_i_imm) ? in.i_imm : in.rs2_data;
    end

    always_comb
    begin
        unique case (in.ctrl.aluop)
            alu_sll: alu_result = alu_a << alu_b[4:0];
            alu_sra: alu_result = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
            alu_sub: alu_result = alu_a - alu_b;
            alu_xor: alu_result = alu_a ^ alu_b;
            alu_srl: alu_result = alu_a >> alu_b[4:0];
            alu_or:  alu_result = alu_a | alu_b;
            alu_and: alu_result = alu_a & alu_b;
            default: alu_result = alu_a + alu_b;
        endcase
    end

    always_comb
    begin
        case (in.ctrl.cmpop)
            beq:     br_en = (in.rs1_data == cmp_b);
            bne:     br_en = (in.rs1_data != cmp_b);
            blt:     br_en = ($signed(in.rs1_data) < $signed(cmp_b));
            bge:     br_en = ($signed(in.rs1_data) >= $signed(cmp_b));
            bltu:    br_en = (in.rs1_data < cmp_b);
            bgeu:    br_en = (in.rs1_data >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    always_comb
    begin
        unique case (in.ctrl.regfilemux_sel)
            rf_br_en: wb_data = {31'b0, br_en};
            rf_u_imm: wb_data = in.u_imm;
            default:  wb_data = alu_result;
        endcase
    end

    assign wb_we     = in.valid & in.ctrl.load_regfile;
    assign wb_rd     = in.ctrl.rd;
    assign br_valid  = in.valid && (in.ctrl.opcode == op_br);
    assign br_taken  = br_valid & br_en;
    assign br_target = alu_result; // pc plus the B immediate for branches
endmodule : execute_stage

// ==== design/rv32i_slice.sv ====
`timescale 1ns/1ps

module rv32i_slice
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  rv32i_types::rv32i_word instr,
    input  rv32i_types::rv32i_word pc,
    output logic                   wb_valid,
    output rv32i_types::rv32i_reg  wb_rd,
    output rv32i_types::rv32i_word wb_data,
    output logic                   br_valid,
    output logic                   br_taken,
    output rv32i_types::rv32i_word br_target
);
    logic wb_we;

    id_ex_if id_ex ();

    decode_stage decode0 (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .out(id_ex.decode)
    );

    execute_stage execute0 (
        .in(id_ex.execute),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

    assign wb_valid = wb_we; // strobe on every real register write including rd of x0
endmodule : rv32i_slice

// ==== testbench/slice_asserts.sv ====
`timescale 1ns/1ps

module slice_asserts
(
    input logic                  clk,
    input logic                  rst,
    input logic                  wb_valid,
    input rv32i_types::rv32i_reg wb_rd,
    input logic                  br_valid
);
    // sampled on the falling edge so the decode register has settled after its edge
    quiet_in_reset: assert property (@(negedge clk) rst |-> !wb_valid && !br_valid)
        else $error("write-back or branch strobe high during reset");

    one_strobe: assert property (@(negedge clk) !(wb_valid && br_valid))
        else $error("write-back and branch strobes high together");

    rd_known: assert property (@(negedge clk) wb_valid |-> !$isunknown(wb_rd))
        else $error("wb_rd unknown while wb_valid is high");
endmodule : slice_asserts

// ==== testbench/tb_rv32i_slice.sv ====
`timescale 1ns/1ps

module tb_rv32i_slice;
    import rv32i_types::*;

    localparam int reset_cycles = 16;
    localparam int n_reset_op   = 6;
    localparam int n_upper      = 16;
    localparam int n_arith      = 160;
    localparam int n_bypass     = 30;
    localparam int n_branch     = 60;
    localparam int n_misc       = 12;
    localparam int n_total      = n_reset_op + n_upper + n_arith + n_bypass + n_branch + n_misc + 2;
    // an instruction needs at most two cycles when an idle gap is put in front of it
    localparam int timeout_cycles = reset_cycles + 2 * n_total + 50;
    localparam logic [6:0] misc_ops [6] = '{7'b0000011, 7'b0100011, 7'b1101111,
                                            7'b1100111, 7'b1110011, 7'b0001011};

    typedef struct {
        logic      we;
        rv32i_reg  rd;
        rv32i_word data;
        logic      br;
        logic      taken;
        rv32i_word target;
        int        cycle;
        string     name;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      instr_valid;
    rv32i_word instr;
    rv32i_word pc;
    logic      wb_valid;
    rv32i_reg  wb_rd;
    rv32i_word wb_data;
    logic      br_valid;
    logic      br_taken;
    rv32i_word br_target;

    logic [31:0] lfsr_state = 32'd27659;
    rv32i_word   model_regs [32];
    expect_t     exp_q [$];
    int          cycle_count = 0; // written only by the stimulus process at rising edges

    rv32i_slice dut0 (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

    bind rv32i_slice slice_asserts asserts0 (
        .clk(clk), .rst(rst), .wb_valid(wb_valid), .wb_rd(wb_rd), .br_valid(br_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'hB4BC_D35C;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic expect_t predict(input rv32i_word word, input rv32i_word pc_val);
        expect_t    e;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  res;
        logic [2:0] f3;
        f3       = word[14:12];
        a        = model_regs[word[19:15]];
        b        = {{20{word[31]}}, word[31:20]};
        res      = '0;
        e.we     = 1'b0;
        e.rd     = word[11:7];
        e.br     = 1'b0;
        e.taken  = 1'b0;
        e.target = '0;
        case (word[6:0])
            7'b0110111:
            begin
                e.we = 1'b1;
                res  = {word[31:12], 12'h000};
            end
            7'b0010111:
            begin
                e.we = 1'b1;
                res  = pc_val + {word[31:12], 12'h000};
            end
            7'b1100011:
            begin
                b        = model_regs[word[24:20]];
                e.br     = 1'b1;
                e.target = pc_val + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
                case (f3)
                    3'b000:  e.taken = (a == b);
                    3'b001:  e.taken = (a != b);
                    3'b100:  e.taken = ($signed(a) < $signed(b));
                    3'b101:  e.taken = ($signed(a) >= $signed(b));
                    3'b110:  e.taken = (a < b);
                    default: e.taken = (a >= b);
                endcase
            end
            7'b0010011, 7'b0110011:
            begin
                e.we = 1'b1;
                if (word[5])
                    b = model_regs[word[24:20]]; // register form takes rs2 instead of the immediate
                case (f3)
                    3'b000:
                        if (word[5] && word[30])
                            res = a - b;
                        else
                            res = a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101:
                        if (word[30])
                            res = $signed(a) >>> b[4:0];
                        else
                            res = a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            default: ; // out of scope so no strobe at all
        endcase
        e.data = res;
        if (e.we && e.rd != 5'd0)
            model_regs[e.rd] = res;
        return e;
    endfunction

    function automatic rv32i_word rand_arith(input logic op_only);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        rv32i_reg    rd;
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        f3  = 3'(take_bits(3));
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        rs2 = 5'(take_bits(5));
        alt = take_bits(1) != 0;
        imm = 12'(take_bits(12));
        if (op_only || take_bits(1) != 0)
        begin
            alt = alt && (f3 == 3'b000 || f3 == 3'b101); // only add and shift right have a variant
            return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
        end
        if (f3 == 3'b001 || f3 == 3'b101)
            imm = {1'b0, alt && f3 == 3'b101, 5'b00000, imm[4:0]};
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv32i_word rand_branch();
        logic [12:0] imm;
        logic [2:0]  f3;
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        imm = {12'(take_bits(12)), 1'b0};
        f3  = 3'(take_bits(3));
        if (f3 == 3'b010 || f3 == 3'b011)
            f3 = f3 ^ 3'b110; // 010 and 011 are not branches so they fold onto blt and bge
        rs1 = 5'(take_bits(5));
        rs2 = (take_bits(1) != 0) ? rs1 : 5'(take_bits(5));
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic check_word(input string name, input rv32i_word expected,
                              input rv32i_word actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input string name, input rv32i_reg expected,
                             input rv32i_reg actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        cycle_count++;
    endtask

    task automatic issue(input string name, input rv32i_word word, input logic gaps);
        expect_t   e;
        rv32i_word pc_val;
        if (gaps && take_bits(2) == 0)
        begin
            next_cycle();
            instr_valid <= 1'b0;
            instr       <= take_bits(32); // junk word while the strobe is low
        end
        next_cycle();
        pc_val  = take_bits(30) << 2;
        e       = predict(word, pc_val);
        e.cycle = cycle_count;
        e.name  = name;
        exp_q.push_back(e);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= pc_val;
    endtask

    // outputs settle after the rising edge, so they are sampled on the falling one
    always @(negedge clk)
    begin : compare_outputs
        expect_t e;
        e.we   = 1'b0;
        e.br   = 1'b0;
        e.name = rst ? "reset" : "idle";
        if (!rst && exp_q.size() != 0 && exp_q[0].cycle + 1 == cycle_count)
            e = exp_q.pop_front();
        check_bit({e.name, " wb_valid"}, e.we, wb_valid);
        check_bit({e.name, " br_valid"}, e.br, br_valid);
        if (e.we)
        begin
            check_reg({e.name, " wb_rd"}, e.rd, wb_rd);
            check_word({e.name, " wb_data"}, e.data, wb_data);
        end
        if (e.br)
        begin
            check_bit({e.name, " br_taken"}, e.taken, br_taken);
            check_word({e.name, " br_target"}, e.target, br_target);
        end
    end

    initial
    begin
        #(timeout_cycles * 20);
        $display("ERROR: watchdog expired, the run hung");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        rv32i_word word;
        rv32i_reg  prev;
        rst         = 1'b1;
        instr_valid = 1'b1; // a live addi during reset must not reach the outputs
        instr       = {12'h001, 5'd0, 3'b000, 5'd1, 7'b0010011};
        pc          = '0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (reset_cycles)
            next_cycle();
        rst         <= 1'b0;
        instr_valid <= 1'b0;

        for (int i = 0; i < n_reset_op; i++)
            issue("reset_op", rand_arith(1'b1), 1'b1);
        for (int i = 0; i < n_upper; i++)
        begin
            word = {20'(take_bits(20)), 5'(take_bits(5)), 7'b0110111};
            if (take_bits(1) != 0)
                word[6:0] = 7'b0010111;
            issue("lui_auipc", word, 1'b1);
        end
        for (int i = 0; i < n_arith; i++)
            issue("arith", rand_arith(1'b0), 1'b1);

        prev = 5'd1;
        for (int i = 0; i < n_bypass; i++)
        begin
            word        = rand_arith(1'b0);
            word[19:15] = prev; // source is the result written one edge earlier
            if (word[11:7] == 5'd0)
                word[11:7] = 5'd3;
            prev = word[11:7];
            issue("bypass", word, 1'b0);
        end

        for (int i = 0; i < n_branch; i++)
            issue("branch", rand_branch(), 1'b1);
        for (int i = 0; i < n_misc; i++)
            issue("no_strobe", {25'(take_bits(25)), misc_ops[i % 6]}, 1'b1);
        issue("x0_write", {12'(take_bits(12)), 5'd5, 3'b000, 5'd0, 7'b0010011}, 1'b0);
        issue("x0_read", {7'h00, 5'd0, 5'd0, 3'b000, 5'd9, 7'b0110011}, 1'b0);

        next_cycle();
        instr_valid <= 1'b0;
        next_cycle();
        next_cycle();
        if (exp_q.size() == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("ERROR: %0d expected results were never checked", exp_q.size());
            $display("Test failed");
            $fatal(1, "unchecked results");
        end
    end
endmodule : tb_rv32i_slice

// ==== filelist.f ====
design/rv32i_types.sv
design/id_ex_if.sv
design/control_rom.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv32i_slice.sv
testbench/slice_asserts.sv
testbench/tb_rv32i_slice.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv32i_slice
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
